/* cnn_pkg.sv */
package cnn_pkg;

    // ================================================
    // Sizes
    // ================================================
    localparam int KX             = 5;           // Kernel width
    localparam int KY             = 5;           // Kernel height
    localparam int KN             = KX * KY;     // Taps per kernel
    localparam int CI             = 2;           // Input channels
    localparam int I_F_BW         = 8;           // Unsigned feature
    localparam int W_BW           = 8;           // Signed weight
    localparam int B_BW           = 16;          // Signed bias
    localparam int M_BW           = 16;          // One product
    localparam int AK_BW          = 21;          // Sum of KN products
    localparam int AC_BW          = 22;          // Sum over both channels
    localparam int O_F_BW         = 23;          // After bias add
    localparam int LATENCY_KERNEL = 2;
    localparam int LATENCY_CORE   = 3;

    // ================================================
    // Configuration address map
    // ================================================
    localparam int CFG_AW       = 5;
    localparam int CFG_DW       = 32;
    localparam int W_PER_WORD   = CFG_DW / W_BW;    // Four weights per word
    localparam int WORDS_PER_CH = 7;                // 28 slots, 25 used
    localparam int ADDR_BIAS    = 16;

    // Host request bundle, addr and data held while req is high
    typedef struct packed {
        logic              req;
        logic [CFG_AW-1:0] addr;
        logic [CFG_DW-1:0] data;
    } cfg_req_t;

    typedef struct packed {
        logic [CFG_DW-B_BW-1:0] pad;
        logic signed [B_BW-1:0] bias;
    } cfg_bias_t;

    // Data word seen either as four weights (byte 0 = lowest tap) or as the bias
    typedef union packed {
        logic [W_PER_WORD-1:0][W_BW-1:0] weights;
        cfg_bias_t                       bias_view;
    } cfg_word_u;

    // One input beat, channel 0 in the low half
    typedef struct packed {
        logic                           valid;
        logic [CI-1:0][KN*I_F_BW-1:0]   window;
    } fmap_beat_t;

    typedef struct packed {
        logic [CI-1:0][KN*W_BW-1:0] weights;
        logic signed [B_BW-1:0]     bias;
    } kernel_set_t;

    typedef struct packed {
        logic              valid;
        logic [O_F_BW-1:0] value;
    } fmap_out_t;

endpackage

/* cnn_kernel.sv */
`timescale 1ns/1ps

module cnn_kernel
    import cnn_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_in_valid,
    input  logic [KN*I_F_BW-1:0]    i_in_fmap,
    input  logic [KN*W_BW-1:0]      i_cnn_weight,
    output logic                    o_ot_valid,
    output logic signed [AK_BW-1:0] o_ot_kernel_acc
);

    // ================================================
    // Valid pipeline
    // ================================================
    // Bit 0 marks the product stage, top bit the sum stage
    logic [LATENCY_KERNEL-1:0] r_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= LATENCY_KERNEL'({r_valid, i_in_valid});
        end
    end

    // ================================================
    // Products
    // ================================================
    logic signed [M_BW-1:0] mul   [KN];
    logic signed [M_BW-1:0] r_mul [KN];

    always_comb begin
        for (int i = 0; i < KN; i++) begin
            // Feature zero-extended, weight sign-extended, result fits in M_BW
            mul[i] = $signed({{(M_BW-I_F_BW){1'b0}}, i_in_fmap[i*I_F_BW +: I_F_BW]})
                   * $signed({{(M_BW-W_BW){i_cnn_weight[i*W_BW+W_BW-1]}},
                              i_cnn_weight[i*W_BW +: W_BW]});
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int i = 0; i < KN; i++) begin
                r_mul[i] <= mul[i];
            end
        end
    end

    // ================================================
    // Adder tree, rows first then total
    // ================================================
    logic signed [AK_BW-1:0] row_sum [KY];
    logic signed [AK_BW-1:0] acc_kernel;
    logic signed [AK_BW-1:0] r_acc_kernel;

    always_comb begin
        for (int y = 0; y < KY; y++) begin
            row_sum[y] = '0;
            for (int x = 0; x < KX; x++) begin
                row_sum[y] = row_sum[y]
                           + {{(AK_BW-M_BW){r_mul[y*KX+x][M_BW-1]}}, r_mul[y*KX+x]};
            end
        end
        acc_kernel = '0;
        for (int y = 0; y < KY; y++) begin
            acc_kernel = acc_kernel + row_sum[y];
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid[0]) begin      // Products of this beat are ready
            r_acc_kernel <= acc_kernel;
        end
    end

    assign o_ot_valid      = r_valid[LATENCY_KERNEL-1];
    assign o_ot_kernel_acc = r_acc_kernel;

endmodule

/* cnn_weight_regs.sv */
`timescale 1ns/1ps

module cnn_weight_regs
    import cnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  cfg_req_t    i_cfg,
    output logic        o_cfg_ack,
    output kernel_set_t o_kernels
);

    // ================================================
    // Four-phase responder
    // ================================================
    logic r_ack;
    logic wr_en;

    // New request only while the previous ack has dropped
    assign wr_en = i_cfg.req && !r_ack;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_ack <= 1'b0;
        end else if (wr_en) begin
            r_ack <= 1'b1;           // Write and ack on the same edge
        end else if (!i_cfg.req) begin
            r_ack <= 1'b0;           // Release once host drops req
        end
    end

    // ================================================
    // Address decode
    // ================================================
    logic [CI-1:0]     ch_hit;       // Address falls in a channel's word range
    logic [CFG_AW-1:0] wr_slot;      // Word index inside that channel
    logic              wr_is_bias;
    int                wr_base;      // First tap covered by the word
    cfg_word_u         wr_word;

    always_comb begin
        ch_hit  = '0;
        wr_slot = '0;
        for (int c = 0; c < CI; c++) begin
            if (i_cfg.addr >= CFG_AW'(c * WORDS_PER_CH) &&
                i_cfg.addr <  CFG_AW'((c + 1) * WORDS_PER_CH)) begin
                ch_hit[c] = 1'b1;
                wr_slot   = i_cfg.addr - CFG_AW'(c * WORDS_PER_CH);
            end
        end
    end

    assign wr_is_bias = (i_cfg.addr == CFG_AW'(ADDR_BIAS));
    assign wr_base    = int'(wr_slot) * W_PER_WORD;
    assign wr_word    = i_cfg.data;

    // ================================================
    // Weight and bias storage
    // ================================================
    kernel_set_t r_kernels;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_kernels <= '0;
        end else if (wr_en) begin
            for (int c = 0; c < CI; c++) begin
                for (int b = 0; b < W_PER_WORD; b++) begin
                    // Slots 25..27 have no tap behind them
                    if (ch_hit[c] && (wr_base + b) < KN) begin
                        r_kernels.weights[c][(wr_base + b)*W_BW +: W_BW]
                            <= wr_word.weights[b];
                    end
                end
            end
            if (wr_is_bias) begin
                r_kernels.bias <= wr_word.bias_view.bias;
            end
        end
    end

    assign o_cfg_ack = r_ack;
    assign o_kernels = r_kernels;

endmodule

/* cnn_core.sv */
`timescale 1ns/1ps

module cnn_core
    import cnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  fmap_beat_t  i_beat,
    input  kernel_set_t i_kernels,
    output fmap_out_t   o_out
);

    localparam int CORE_STAGES = LATENCY_CORE - LATENCY_KERNEL;

    // ================================================
    // Per-channel kernels
    // ================================================
    logic                    ch0_valid;
    logic signed [AK_BW-1:0] ch0_acc;
    logic signed [AK_BW-1:0] ch1_acc;

    cnn_kernel u_kernel_ch0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_in_valid      (i_beat.valid),
        .i_in_fmap       (i_beat.window[0]),
        .i_cnn_weight    (i_kernels.weights[0]),
        .o_ot_valid      (ch0_valid),
        .o_ot_kernel_acc (ch0_acc)
    );

    // Same valid input as ch0, so its valid output is identical
    cnn_kernel u_kernel_ch1 (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_in_valid      (i_beat.valid),
        .i_in_fmap       (i_beat.window[1]),
        .i_cnn_weight    (i_kernels.weights[1]),
        .o_ot_valid      (),
        .o_ot_kernel_acc (ch1_acc)
    );

    // ================================================
    // Channel sum, bias and ReLU
    // ================================================
    logic signed [AC_BW-1:0]  ch_sum;
    logic signed [O_F_BW-1:0] pre_act;
    logic [O_F_BW-1:0]        relu;

    assign ch_sum  = {{(AC_BW-AK_BW){ch0_acc[AK_BW-1]}}, ch0_acc}
                   + {{(AC_BW-AK_BW){ch1_acc[AK_BW-1]}}, ch1_acc};

    assign pre_act = {{(O_F_BW-AC_BW){ch_sum[AC_BW-1]}}, ch_sum}
                   + {{(O_F_BW-B_BW){i_kernels.bias[B_BW-1]}}, i_kernels.bias};

    assign relu = pre_act[O_F_BW-1] ? '0 : pre_act;  // Clamp negatives

    // ================================================
    // Output register
    // ================================================
    logic [CORE_STAGES-1:0] r_stage_valid;
    logic [O_F_BW-1:0]      r_value;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_stage_valid <= '0;
        end else begin
            r_stage_valid <= CORE_STAGES'({r_stage_valid, ch0_valid});
        end
    end

    // Holds last result while no beat arrives
    always_ff @(posedge clk) begin
        if (ch0_valid) begin
            r_value <= relu;
        end
    end

    assign o_out = '{valid: r_stage_valid[CORE_STAGES-1], value: r_value};

endmodule

/* cnn_top.sv */
`timescale 1ns/1ps

module cnn_top
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  cfg_req_t   i_cfg,
    output logic       o_cfg_ack,
    input  fmap_beat_t i_beat,
    output fmap_out_t  o_out
);

    // Weights and bias from the register block to the core
    kernel_set_t kernels;

    // ================================================
    // Configuration registers
    // ================================================
    cnn_weight_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_cfg     (i_cfg),
        .o_cfg_ack (o_cfg_ack),
        .o_kernels (kernels)
    );

    // ================================================
    // Convolution core
    // ================================================
    cnn_core u_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_beat    (i_beat),
        .i_kernels (kernels),
        .o_out     (o_out)
    );

endmodule

/* tb_cnn_top.sv */
`timescale 1ns/1ps

module tb_cnn_top
    import cnn_pkg::*;
();

    localparam int ROW_BW = KX * I_F_BW;    // One window row of five taps
    localparam int ROWS   = CI * KY;        // Row words per stim beat

    // One outstanding beat
    typedef struct packed {
        logic [31:0]       capture;         // Last rising edge before the beat is driven
        logic [O_F_BW-1:0] value;
    } expect_t;

    logic        clk;
    logic        reset_n;
    cfg_req_t    cfg;
    logic        cfg_ack;
    fmap_beat_t  beat;
    fmap_out_t   dut_out;

    int          cycle;
    int          timeout_limit;
    logic        limit_ready;
    int          mismatch_count;
    int          other_count;
    int          ack_rises;
    int          writes_done;
    logic        prev_ack;
    logic [31:0] rng_state;
    expect_t     exp_e;
    expect_t     expected_q [$];
    string       stim_lines [$];

    cnn_top dut0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_cfg     (cfg),
        .o_cfg_ack (cfg_ack),
        .i_beat    (beat),
        .o_out     (dut_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ================================================
    // Helpers
    // ================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, got, expected, cycle);
            mismatch_count++;
        end
    endtask

    task automatic note_error(input string what);
        $display("Error at cycle %0d: %s", cycle, what);
        other_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            beat.valid = 1'b0;
        end
    endtask

    // Stop sending and wait until every beat has come out
    task automatic drain_pipeline();
        @(negedge clk);
        beat.valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Host side of the four-phase handshake
    task automatic write_cfg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data);
        int waits;
        drain_pipeline();                   // No beats in flight while weights change
        check_value("o_cfg_ack before req", 64'(cfg_ack), 64'd0);
        cfg.req  = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!cfg_ack);
        check_value("cycles from req to ack", 64'(waits), 64'd1);
        @(negedge clk);                     // Hold req one more cycle
        check_value("o_cfg_ack while req held", 64'(cfg_ack), 64'd1);
        cfg.req = 1'b0;                     // Ack still high here
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (cfg_ack);
        check_value("cycles from req drop to ack drop", 64'(waits), 64'd1);
        writes_done++;
    endtask

    task automatic send_beat(input logic [CI-1:0][KN*I_F_BW-1:0] win,
                             input logic [O_F_BW-1:0] value);
        expect_t e;
        @(negedge clk);
        beat.valid  = 1'b1;
        beat.window = win;
        e.capture   = 32'(cycle);           // Latency counts from this edge
        e.value     = value;
        expected_q.push_back(e);
    endtask

    task automatic run_line(input string line);
        logic [31:0]                  addr_v;
        logic [31:0]                  data_v;
        logic [31:0]                  exp_v;
        logic [ROW_BW-1:0]            rows [ROWS];
        logic [CI-1:0][KN*I_F_BW-1:0] win;
        int                           n;
        int                           count;
        if (line.len() >= 2 && line.getc(0) != "#") begin
            case (line.getc(0))
                "W": begin
                    count = $sscanf(line, "W %h %h", addr_v, data_v);
                    if (count != 2) begin
                        note_error({"malformed write line: ", line});
                    end else begin
                        write_cfg(addr_v[CFG_AW-1:0], data_v);
                    end
                end
                "B": begin
                    count = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h %h",
                                    rows[0], rows[1], rows[2], rows[3], rows[4],
                                    rows[5], rows[6], rows[7], rows[8], rows[9], exp_v);
                    if (count != ROWS + 1) begin
                        note_error({"malformed beat line: ", line});
                    end else begin
                        for (int c = 0; c < CI; c++) begin
                            for (int r = 0; r < KY; r++) begin
                                win[c][r*ROW_BW +: ROW_BW] = rows[c*KY + r];
                            end
                        end
                        send_beat(win, exp_v[O_F_BW-1:0]);
                        rng_state = xorshift32(rng_state);
                        if (rng_state[4]) begin
                            idle_cycles(int'(rng_state[1:0]));  // Random gap 0..3
                        end
                    end
                end
                "G": begin
                    count = $sscanf(line, "G %d", n);
                    if (count != 1) begin
                        note_error({"malformed gap line: ", line});
                    end else begin
                        idle_cycles(n);
                    end
                end
                default: note_error({"unknown stim tag in line: ", line});
            endcase
        end
    endtask

    // ================================================
    // Output and ack monitor
    // ================================================
    always @(negedge clk) begin
        if (reset_n) begin
            if (cfg_ack && !prev_ack) begin
                ack_rises++;
            end
            if (dut_out.valid) begin
                if (expected_q.size() == 0) begin
                    note_error("o_out.valid high with no beat outstanding");
                end else begin
                    exp_e = expected_q.pop_front();
                    check_value("o_out.value", 64'(dut_out.value), 64'(exp_e.value));
                    check_value("o_out latency in cycles",
                                64'(cycle) - 64'(exp_e.capture), 64'(LATENCY_CORE));
                end
            end
        end
        prev_ack = cfg_ack;
    end

    // ================================================
    // Main sequence
    // ================================================
    initial begin : main_seq
        int    fd;
        int    got;
        string line;
        reset_n     = 1'b0;
        cfg         = '0;
        beat        = '0;
        rng_state   = 32'd28;
        limit_ready = 1'b0;

        fd = $fopen("cnn_stim.txt", "r");
        if (fd == 0) begin
            note_error("cannot open stimulus file cnn_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                if (got != 0) begin
                    stim_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        timeout_limit = 20 * stim_lines.size() + 100;
        limit_ready   = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("o_cfg_ack after reset", 64'(cfg_ack), 64'd0);
        check_value("o_out.valid after reset", 64'(dut_out.valid), 64'd0);

        foreach (stim_lines[i]) begin
            run_line(stim_lines[i]);
        end

        drain_pipeline();
        idle_cycles(8);                     // Window for any stray output valid
        if (expected_q.size() != 0) begin
            note_error("beats still waiting for an output at the end");
        end
        check_value("ack count", 64'(ack_rises), 64'(writes_done));

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Timeout from the stim length
    initial begin : watchdog
        wait (limit_ready);
        while (cycle < timeout_limit) begin
            @(posedge clk);
        end
        $display("Timeout: run stopped at cycle %0d with %0d outputs still expected",
                 cycle, expected_q.size());
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count,
                 other_count + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

/* cnn_stim.txt */
# W addr data (hex) | G idle cycles (decimal) | B ch0 rows 0-4, ch1 rows 0-4, expected (hex)
# A row word holds taps 5r..5r+4 of its channel, lowest tap in the low byte
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 000000
G 4
W 00 01010101
W 01 01010101
W 02 01010101
W 03 01010101
W 04 01010101
W 05 01010101
W 06 AAAAAA7F
W 07 FFFFFFFF
W 08 FFFFFFFF
W 09 FFFFFFFF
W 0A FFFFFFFF
W 0B FFFFFFFF
W 0C FFFFFFFF
W 0D 55555580
W 10 ABCD0010
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 0000000000 0000000000 0000000000 0000000000 0000000000 009679
G 6
B 0000000000 0000000000 0000000000 0000000000 FF00000000 0000000000 0000000000 0000000000 0000000000 0000000000 007E91
G 6
B 0000000000 0000000000 0000000000 0000000000 0000000000 FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 000000
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 000000
B 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 00000F
B 0202020202 0202020202 0202020202 0202020202 0202020202 0000000000 0000000000 0000000000 0000000000 0000000000 00013E
B 00000000FF 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0100000000 00008F
B 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 FF00000000 000000
B 0000000000 0000000010 0000000000 0000000000 0000000000 0008000000 0000000000 0000000000 0000000000 0000000000 000018
B 0000000000 0000000000 0102030405 0000000000 0000000000 0000000000 0A00000000 0000000000 0000000000 0000000000 000015
B 0000000000 0000000000 0000000000 0000000000 0000000080 0000000000 0000000000 0000000000 0000000000 0000000000 000090
G 3
W 10 0000FF00
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 0000000000 0000000000 0000000000 0000000000 0000000000 009569
B 0000000000 0000000000 0000000000 0000000000 FF00000000 0000000000 0000000000 0000000000 0000000000 0000000000 007D81
B 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 0101010101 000000
B 0202020202 0202020202 0202020202 0202020202 0202020202 0000000000 0000000000 0000000000 0000000000 0000000000 00002E
B 0000000000 0000000010 0000000000 0000000000 0000000000 0008000000 0000000000 0000000000 0000000000 0000000000 000000
W 10 12347FFF
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 007F00
B 0000000000 0000000000 0000000000 0000000000 0000000000 FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 000000
B 0000000000 0000000000 0000000000 0000000000 0000000000 0101010101 0101010101 0101010101 0101010101 0101010101 007F67
B 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 007FFF
W 0E FFFFFFFF
W 0F 80808080
W 11 7F7F7F7F
W 15 FFFFFFFF
W 1F 80808080
W 06 8080807F
W 0D 7F7F7F80
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 007F00
B 0000000000 0000000000 0000000000 0000000000 0000000000 0101010101 0101010101 0101010101 0101010101 0101010101 007F67
B FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF 0000000000 0000000000 0000000000 0000000000 0000000000 011668
B 0000000000 0000000000 0000000000 0000000000 FF00000000 0000000000 0000000000 0000000000 0000000000 FF00000000 007F00
W 00 80808080
B 00000000FF 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 00007F
B 0000000001 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 007F7F
W 10 00008000
B 0000000000 0000000000 0000000000 0000000000 FFFFFFFFFF 0000000000 0000000000 0000000000 0000000000 0000000000 00027D
B 0000000000 0000000000 0000000000 0000000000 FF00000000 0000000000 0000000000 0000000000 0000000000 0000000000 000000
G 2

/* cnn_top.f */
cnn_pkg.sv
cnn_kernel.sv
cnn_weight_regs.sv
cnn_core.sv
cnn_top.sv
tb_cnn_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cnn_top
FILELIST  ?= cnn_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Verification failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test: FAILED"; \
		exit 1; \
	fi; \
	echo "test: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
